// ==== common/decode_pkg.sv ====
package decode_pkg;

    localparam int XLEN        = 32;
    localparam int REG_ADDR_W  = 5;
    localparam int EXC_CAUSE_W = 6;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    localparam reg_addr_t LINK_REG = 5'd1;

    typedef enum logic [7:0] {
        ALU_NOP,
        ALU_SLTI, ALU_SLTUI, ALU_ADDIW, ALU_ANDI, ALU_ORI, ALU_XORI,
        ALU_ADDW, ALU_SUBW, ALU_SLT, ALU_SLTU, ALU_NOR, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLLW, ALU_SRLW, ALU_SRAW,
        ALU_MULW, ALU_MULHW, ALU_MULHWU,
        ALU_DIVW, ALU_MODW, ALU_DIVWU, ALU_MODWU,
        ALU_SLLIW, ALU_SRLIW, ALU_SRAIW,
        ALU_LU12I, ALU_PCADDU12I,
        ALU_LDB, ALU_LDH, ALU_LDW, ALU_LDBU, ALU_LDHU,
        ALU_STB, ALU_STH, ALU_STW,
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU,
        ALU_B, ALU_BL, ALU_JIRL,
        ALU_BREAK, ALU_SYSCALL
    } aluop_e;

    typedef enum logic [2:0] {
        SEL_NOP,
        SEL_ARITH,
        SEL_DIV,
        SEL_LOAD_STORE,
        SEL_JUMP_BRANCH
    } alusel_e;

    // loongarch ecode values
    typedef enum logic [EXC_CAUSE_W-1:0] {
        SYS = 6'h0b,
        BRK = 6'h0c,
        INE = 6'h0d
    } exc_cause_e;

    // inst[31:22]
    localparam logic [9:0] OP10_SLTI  = 10'h008;
    localparam logic [9:0] OP10_SLTUI = 10'h009;
    localparam logic [9:0] OP10_ADDIW = 10'h00a;
    localparam logic [9:0] OP10_ANDI  = 10'h00d;
    localparam logic [9:0] OP10_ORI   = 10'h00e;
    localparam logic [9:0] OP10_XORI  = 10'h00f;
    localparam logic [9:0] OP10_LDB   = 10'h0a0;
    localparam logic [9:0] OP10_LDH   = 10'h0a1;
    localparam logic [9:0] OP10_LDW   = 10'h0a2;
    localparam logic [9:0] OP10_STB   = 10'h0a4;
    localparam logic [9:0] OP10_STH   = 10'h0a5;
    localparam logic [9:0] OP10_STW   = 10'h0a6;
    localparam logic [9:0] OP10_LDBU  = 10'h0a8;
    localparam logic [9:0] OP10_LDHU  = 10'h0a9;

    // inst[31:15]
    localparam logic [16:0] OP17_ADDW    = 17'h00020;
    localparam logic [16:0] OP17_SUBW    = 17'h00022;
    localparam logic [16:0] OP17_SLT     = 17'h00024;
    localparam logic [16:0] OP17_SLTU    = 17'h00025;
    localparam logic [16:0] OP17_NOR     = 17'h00028;
    localparam logic [16:0] OP17_AND     = 17'h00029;
    localparam logic [16:0] OP17_OR      = 17'h0002a;
    localparam logic [16:0] OP17_XOR     = 17'h0002b;
    localparam logic [16:0] OP17_SLLW    = 17'h0002e;
    localparam logic [16:0] OP17_SRLW    = 17'h0002f;
    localparam logic [16:0] OP17_SRAW    = 17'h00030;
    localparam logic [16:0] OP17_MULW    = 17'h00038;
    localparam logic [16:0] OP17_MULHW   = 17'h00039;
    localparam logic [16:0] OP17_MULHWU  = 17'h0003a;
    localparam logic [16:0] OP17_DIVW    = 17'h00040;
    localparam logic [16:0] OP17_MODW    = 17'h00041;
    localparam logic [16:0] OP17_DIVWU   = 17'h00042;
    localparam logic [16:0] OP17_MODWU   = 17'h00043;
    localparam logic [16:0] OP17_BREAK   = 17'h00054;
    localparam logic [16:0] OP17_SYSCALL = 17'h00056;
    localparam logic [16:0] OP17_SLLIW   = 17'h00081;
    localparam logic [16:0] OP17_SRLIW   = 17'h00089;
    localparam logic [16:0] OP17_SRAIW   = 17'h00091;

    // inst[31:25]
    localparam logic [6:0] OP7_LU12I     = 7'h0a;
    localparam logic [6:0] OP7_PCADDU12I = 7'h0e;

    // inst[31:26]
    localparam logic [5:0] OP6_JIRL = 6'h13;
    localparam logic [5:0] OP6_B    = 6'h14;
    localparam logic [5:0] OP6_BL   = 6'h15;
    localparam logic [5:0] OP6_BEQ  = 6'h16;
    localparam logic [5:0] OP6_BNE  = 6'h17;
    localparam logic [5:0] OP6_BLT  = 6'h18;
    localparam logic [5:0] OP6_BGE  = 6'h19;
    localparam logic [5:0] OP6_BLTU = 6'h1a;
    localparam logic [5:0] OP6_BGEU = 6'h1b;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } fetch_pkt_t;

    typedef struct packed {
        word_t      pc;
        aluop_e     aluop;
        alusel_e    alusel;
        logic [1:0] read_en;
        reg_addr_t  read_addr0;
        reg_addr_t  read_addr1;
        logic       write_en;
        reg_addr_t  write_addr;
        word_t      imm;
        logic       exc;
        exc_cause_e exc_cause;
    } dispatch_pkt_t;

endpackage

// ==== hw/pipe_slot.sv ====
`timescale 1ns/100ps

module pipe_slot #(
    parameter type payload_t = decode_pkg::word_t
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  logic     valid_i,
    input  payload_t data_i,
    output logic     ready_o,
    output logic     valid_o,
    output payload_t data_o,
    input  logic     ready_i
);

    logic     full_q;
    payload_t data_q;
    logic     load;

    // room when empty or when the held entry drains this cycle
    assign ready_o = ~full_q | ready_i;
    assign load    = valid_i & ready_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            full_q <= 1'b0;
        end else if (ready_o) begin
            full_q <= valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (load) begin
            data_q <= data_i;
        end
    end

    assign valid_o = full_q;
    assign data_o  = data_q;

endmodule

// ==== decode/alu_decoder.sv ====
`timescale 1ns/100ps

module alu_decoder (
    input  decode_pkg::word_t      inst_i,
    output logic                   hit_o,
    output decode_pkg::aluop_e     aluop_o,
    output decode_pkg::alusel_e    alusel_o,
    output logic [1:0]             read_en_o,
    output decode_pkg::reg_addr_t  read_addr0_o,
    output logic                   write_en_o,
    output decode_pkg::word_t      imm_o,
    output logic                   exc_o,
    output decode_pkg::exc_cause_e exc_cause_o
);

    import decode_pkg::*;

    logic [9:0]  op10;
    logic [16:0] op17;
    logic [6:0]  op7;

    assign op10 = inst_i[31:22];
    assign op17 = inst_i[31:15];
    assign op7  = inst_i[31:25];

    // opcode match
    always_comb begin
        aluop_o = ALU_NOP;
        case (op10)
            OP10_SLTI:  aluop_o = ALU_SLTI;
            OP10_SLTUI: aluop_o = ALU_SLTUI;
            OP10_ADDIW: aluop_o = ALU_ADDIW;
            OP10_ANDI:  aluop_o = ALU_ANDI;
            OP10_ORI:   aluop_o = ALU_ORI;
            OP10_XORI:  aluop_o = ALU_XORI;
            default: ;
        endcase
        case (op17)
            OP17_ADDW:    aluop_o = ALU_ADDW;
            OP17_SUBW:    aluop_o = ALU_SUBW;
            OP17_SLT:     aluop_o = ALU_SLT;
            OP17_SLTU:    aluop_o = ALU_SLTU;
            OP17_NOR:     aluop_o = ALU_NOR;
            OP17_AND:     aluop_o = ALU_AND;
            OP17_OR:      aluop_o = ALU_OR;
            OP17_XOR:     aluop_o = ALU_XOR;
            OP17_SLLW:    aluop_o = ALU_SLLW;
            OP17_SRLW:    aluop_o = ALU_SRLW;
            OP17_SRAW:    aluop_o = ALU_SRAW;
            OP17_MULW:    aluop_o = ALU_MULW;
            OP17_MULHW:   aluop_o = ALU_MULHW;
            OP17_MULHWU:  aluop_o = ALU_MULHWU;
            OP17_DIVW:    aluop_o = ALU_DIVW;
            OP17_MODW:    aluop_o = ALU_MODW;
            OP17_DIVWU:   aluop_o = ALU_DIVWU;
            OP17_MODWU:   aluop_o = ALU_MODWU;
            OP17_SLLIW:   aluop_o = ALU_SLLIW;
            OP17_SRLIW:   aluop_o = ALU_SRLIW;
            OP17_SRAIW:   aluop_o = ALU_SRAIW;
            OP17_BREAK:   aluop_o = ALU_BREAK;
            OP17_SYSCALL: aluop_o = ALU_SYSCALL;
            default: ;
        endcase
        case (op7)
            OP7_LU12I:     aluop_o = ALU_LU12I;
            OP7_PCADDU12I: aluop_o = ALU_PCADDU12I;
            default: ;
        endcase
    end

    // operand and immediate shape per operation class
    always_comb begin
        hit_o        = (aluop_o != ALU_NOP);
        alusel_o     = SEL_ARITH;
        read_en_o    = 2'b01;
        read_addr0_o = inst_i[9:5];
        write_en_o   = 1'b1;
        imm_o        = '0;
        exc_o        = 1'b0;
        exc_cause_o  = INE;
        case (aluop_o)
            ALU_SLTI, ALU_SLTUI, ALU_ADDIW:
                imm_o = {{20{inst_i[21]}}, inst_i[21:10]};
            ALU_ANDI, ALU_ORI, ALU_XORI:
                imm_o = {20'b0, inst_i[21:10]};
            ALU_SLLIW, ALU_SRLIW, ALU_SRAIW:
                imm_o = {27'b0, inst_i[14:10]};
            ALU_ADDW, ALU_SUBW, ALU_SLT, ALU_SLTU, ALU_NOR, ALU_AND, ALU_OR, ALU_XOR,
            ALU_SLLW, ALU_SRLW, ALU_SRAW, ALU_MULW, ALU_MULHW, ALU_MULHWU:
                read_en_o = 2'b11;
            ALU_DIVW, ALU_MODW, ALU_DIVWU, ALU_MODWU: begin
                alusel_o  = SEL_DIV;
                read_en_o = 2'b11;
            end
            ALU_LU12I: begin
                // r0 + imm
                read_addr0_o = '0;
                imm_o        = {inst_i[24:5], 12'b0};
            end
            ALU_PCADDU12I:
                imm_o = {inst_i[24:5], 12'b0};
            ALU_BREAK, ALU_SYSCALL: begin
                alusel_o    = SEL_NOP;
                read_en_o   = 2'b00;
                write_en_o  = 1'b0;
                exc_o       = 1'b1;
                exc_cause_o = (aluop_o == ALU_BREAK) ? BRK : SYS;
            end
            default: begin
                alusel_o   = SEL_NOP;
                read_en_o  = 2'b00;
                write_en_o = 1'b0;
            end
        endcase
    end

endmodule

// ==== decode/mem_branch_decoder.sv ====
`timescale 1ns/100ps

module mem_branch_decoder (
    input  decode_pkg::word_t     inst_i,
    output logic                  hit_o,
    output decode_pkg::aluop_e    aluop_o,
    output decode_pkg::alusel_e   alusel_o,
    output logic [1:0]            read_en_o,
    output decode_pkg::reg_addr_t read_addr1_o,
    output logic                  write_en_o,
    output decode_pkg::reg_addr_t write_addr_o,
    output decode_pkg::word_t     imm_o
);

    import decode_pkg::*;

    logic [9:0] op10;
    logic [5:0] op6;
    reg_addr_t  rk;
    reg_addr_t  rd;

    assign op10 = inst_i[31:22];
    assign op6  = inst_i[31:26];
    assign rk   = inst_i[14:10];
    assign rd   = inst_i[4:0];

    always_comb begin
        aluop_o = ALU_NOP;
        case (op10)
            OP10_LDB:  aluop_o = ALU_LDB;
            OP10_LDH:  aluop_o = ALU_LDH;
            OP10_LDW:  aluop_o = ALU_LDW;
            OP10_LDBU: aluop_o = ALU_LDBU;
            OP10_LDHU: aluop_o = ALU_LDHU;
            OP10_STB:  aluop_o = ALU_STB;
            OP10_STH:  aluop_o = ALU_STH;
            OP10_STW:  aluop_o = ALU_STW;
            default: ;
        endcase
        case (op6)
            OP6_BEQ:  aluop_o = ALU_BEQ;
            OP6_BNE:  aluop_o = ALU_BNE;
            OP6_BLT:  aluop_o = ALU_BLT;
            OP6_BGE:  aluop_o = ALU_BGE;
            OP6_BLTU: aluop_o = ALU_BLTU;
            OP6_BGEU: aluop_o = ALU_BGEU;
            OP6_B:    aluop_o = ALU_B;
            OP6_BL:   aluop_o = ALU_BL;
            OP6_JIRL: aluop_o = ALU_JIRL;
            default: ;
        endcase
    end

    always_comb begin
        hit_o        = (aluop_o != ALU_NOP);
        alusel_o     = SEL_JUMP_BRANCH;
        read_en_o    = 2'b00;
        read_addr1_o = rk;
        write_en_o   = 1'b0;
        write_addr_o = rd;
        imm_o        = '0;
        case (aluop_o)
            ALU_LDB, ALU_LDH, ALU_LDW, ALU_LDBU, ALU_LDHU: begin
                alusel_o   = SEL_LOAD_STORE;
                read_en_o  = 2'b01;
                write_en_o = 1'b1;
                imm_o      = {{20{inst_i[21]}}, inst_i[21:10]};
            end
            ALU_STB, ALU_STH, ALU_STW: begin
                // store data comes from rd
                alusel_o     = SEL_LOAD_STORE;
                read_en_o    = 2'b11;
                read_addr1_o = rd;
            end
            ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU: begin
                read_en_o    = 2'b11;
                read_addr1_o = rd;
            end
            ALU_BL: begin
                write_en_o   = 1'b1;
                write_addr_o = LINK_REG;
            end
            ALU_JIRL: begin
                read_en_o  = 2'b01;
                write_en_o = 1'b1;
            end
            ALU_B: ;
            default:
                alusel_o = SEL_NOP;
        endcase
    end

endmodule

// ==== decode/inst_decoder.sv ====
`timescale 1ns/100ps

module inst_decoder (
    input  decode_pkg::word_t      inst_i,
    output decode_pkg::aluop_e     aluop_o,
    output decode_pkg::alusel_e    alusel_o,
    output logic [1:0]             read_en_o,
    output decode_pkg::reg_addr_t  read_addr0_o,
    output decode_pkg::reg_addr_t  read_addr1_o,
    output logic                   write_en_o,
    output decode_pkg::reg_addr_t  write_addr_o,
    output decode_pkg::word_t      imm_o,
    output logic                   exc_o,
    output decode_pkg::exc_cause_e exc_cause_o
);

    import decode_pkg::*;

    reg_addr_t  rj;
    reg_addr_t  rk;
    reg_addr_t  rd;

    logic       alu_hit;
    aluop_e     alu_aluop;
    alusel_e    alu_alusel;
    logic [1:0] alu_read_en;
    reg_addr_t  alu_read_addr0;
    logic       alu_write_en;
    word_t      alu_imm;
    logic       alu_exc;
    exc_cause_e alu_exc_cause;

    logic       mb_hit;
    aluop_e     mb_aluop;
    alusel_e    mb_alusel;
    logic [1:0] mb_read_en;
    reg_addr_t  mb_read_addr1;
    logic       mb_write_en;
    reg_addr_t  mb_write_addr;
    word_t      mb_imm;

    assign rk = inst_i[14:10];
    assign rj = inst_i[9:5];
    assign rd = inst_i[4:0];

    alu_decoder alu_dec (
        .inst_i       (inst_i),
        .hit_o        (alu_hit),
        .aluop_o      (alu_aluop),
        .alusel_o     (alu_alusel),
        .read_en_o    (alu_read_en),
        .read_addr0_o (alu_read_addr0),
        .write_en_o   (alu_write_en),
        .imm_o        (alu_imm),
        .exc_o        (alu_exc),
        .exc_cause_o  (alu_exc_cause)
    );

    mem_branch_decoder mb_dec (
        .inst_i       (inst_i),
        .hit_o        (mb_hit),
        .aluop_o      (mb_aluop),
        .alusel_o     (mb_alusel),
        .read_en_o    (mb_read_en),
        .read_addr1_o (mb_read_addr1),
        .write_en_o   (mb_write_en),
        .write_addr_o (mb_write_addr),
        .imm_o        (mb_imm)
    );

    // groups are disjoint, a miss in both is an invalid instruction
    always_comb begin
        aluop_o      = ALU_NOP;
        alusel_o     = SEL_NOP;
        read_en_o    = 2'b00;
        read_addr0_o = rj;
        read_addr1_o = rk;
        write_en_o   = 1'b0;
        write_addr_o = rd;
        imm_o        = '0;
        exc_o        = 1'b1;
        exc_cause_o  = INE;
        if (alu_hit) begin
            aluop_o      = alu_aluop;
            alusel_o     = alu_alusel;
            read_en_o    = alu_read_en;
            read_addr0_o = alu_read_addr0;
            write_en_o   = alu_write_en;
            imm_o        = alu_imm;
            exc_o        = alu_exc;
            exc_cause_o  = alu_exc_cause;
        end else if (mb_hit) begin
            aluop_o      = mb_aluop;
            alusel_o     = mb_alusel;
            read_en_o    = mb_read_en;
            read_addr1_o = mb_read_addr1;
            write_en_o   = mb_write_en;
            write_addr_o = mb_write_addr;
            imm_o        = mb_imm;
            exc_o        = 1'b0;
        end
    end

endmodule

// ==== hw/decode_stage.sv ====
`timescale 1ns/100ps

module decode_stage (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   in_valid_i,
    input  decode_pkg::word_t      pc_i,
    input  decode_pkg::word_t      inst_i,
    output logic                   in_ready_o,
    output logic                   out_valid_o,
    input  logic                   out_ready_i,
    output decode_pkg::word_t      pc_o,
    output decode_pkg::aluop_e     aluop_o,
    output decode_pkg::alusel_e    alusel_o,
    output logic [1:0]             read_en_o,
    output decode_pkg::reg_addr_t  read_addr0_o,
    output decode_pkg::reg_addr_t  read_addr1_o,
    output logic                   write_en_o,
    output decode_pkg::reg_addr_t  write_addr_o,
    output decode_pkg::word_t      imm_o,
    output logic                   exc_o,
    output decode_pkg::exc_cause_e exc_cause_o
);

    import decode_pkg::*;

    fetch_pkt_t    fetch_in;
    fetch_pkt_t    fetch_q;
    logic          fetch_valid;
    logic          dispatch_ready;
    dispatch_pkt_t dispatch_d;
    dispatch_pkt_t dispatch_q;

    assign fetch_in.pc   = pc_i;
    assign fetch_in.inst = inst_i;

    pipe_slot #(
        .payload_t (fetch_pkt_t)
    ) fetch_slot (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (in_valid_i),
        .data_i   (fetch_in),
        .ready_o  (in_ready_o),
        .valid_o  (fetch_valid),
        .data_o   (fetch_q),
        .ready_i  (dispatch_ready)
    );

    assign dispatch_d.pc = fetch_q.pc;

    inst_decoder decoder (
        .inst_i       (fetch_q.inst),
        .aluop_o      (dispatch_d.aluop),
        .alusel_o     (dispatch_d.alusel),
        .read_en_o    (dispatch_d.read_en),
        .read_addr0_o (dispatch_d.read_addr0),
        .read_addr1_o (dispatch_d.read_addr1),
        .write_en_o   (dispatch_d.write_en),
        .write_addr_o (dispatch_d.write_addr),
        .imm_o        (dispatch_d.imm),
        .exc_o        (dispatch_d.exc),
        .exc_cause_o  (dispatch_d.exc_cause)
    );

    pipe_slot #(
        .payload_t (dispatch_pkt_t)
    ) dispatch_slot (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .valid_i  (fetch_valid),
        .data_i   (dispatch_d),
        .ready_o  (dispatch_ready),
        .valid_o  (out_valid_o),
        .data_o   (dispatch_q),
        .ready_i  (out_ready_i)
    );

    assign pc_o         = dispatch_q.pc;
    assign aluop_o      = dispatch_q.aluop;
    assign alusel_o     = dispatch_q.alusel;
    assign read_en_o    = dispatch_q.read_en;
    assign read_addr0_o = dispatch_q.read_addr0;
    assign read_addr1_o = dispatch_q.read_addr1;
    assign write_en_o   = dispatch_q.write_en;
    assign write_addr_o = dispatch_q.write_addr;
    assign imm_o        = dispatch_q.imm;
    assign exc_o        = dispatch_q.exc;
    assign exc_cause_o  = dispatch_q.exc_cause;

endmodule

// ==== verif/decode_model.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

// kept opcodes per field width, paired with the operation they decode to
logic [9:0] op10_code [14] = '{
    OP10_SLTI, OP10_SLTUI, OP10_ADDIW, OP10_ANDI, OP10_ORI, OP10_XORI, OP10_LDB,
    OP10_LDH, OP10_LDW, OP10_LDBU, OP10_LDHU, OP10_STB, OP10_STH, OP10_STW
};
aluop_e op10_op [14] = '{
    ALU_SLTI, ALU_SLTUI, ALU_ADDIW, ALU_ANDI, ALU_ORI, ALU_XORI, ALU_LDB,
    ALU_LDH, ALU_LDW, ALU_LDBU, ALU_LDHU, ALU_STB, ALU_STH, ALU_STW
};
logic [16:0] op17_code [23] = '{
    OP17_ADDW, OP17_SUBW, OP17_SLT, OP17_SLTU, OP17_NOR, OP17_AND, OP17_OR, OP17_XOR,
    OP17_SLLW, OP17_SRLW, OP17_SRAW, OP17_MULW, OP17_MULHW, OP17_MULHWU, OP17_DIVW,
    OP17_MODW, OP17_DIVWU, OP17_MODWU, OP17_BREAK, OP17_SYSCALL, OP17_SLLIW,
    OP17_SRLIW, OP17_SRAIW
};
aluop_e op17_op [23] = '{
    ALU_ADDW, ALU_SUBW, ALU_SLT, ALU_SLTU, ALU_NOR, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLLW, ALU_SRLW, ALU_SRAW, ALU_MULW, ALU_MULHW, ALU_MULHWU, ALU_DIVW,
    ALU_MODW, ALU_DIVWU, ALU_MODWU, ALU_BREAK, ALU_SYSCALL, ALU_SLLIW,
    ALU_SRLIW, ALU_SRAIW
};
logic [6:0] op7_code [2] = '{OP7_LU12I, OP7_PCADDU12I};
aluop_e op7_op [2] = '{ALU_LU12I, ALU_PCADDU12I};
logic [5:0] op6_code [9] = '{
    OP6_JIRL, OP6_B, OP6_BL, OP6_BEQ, OP6_BNE, OP6_BLT, OP6_BGE, OP6_BLTU, OP6_BGEU
};
aluop_e op6_op [9] = '{
    ALU_JIRL, ALU_B, ALU_BL, ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
};

function automatic aluop_e classify(input word_t inst);
    foreach (op10_code[i]) begin
        if (inst[31:22] == op10_code[i]) begin
            return op10_op[i];
        end
    end
    foreach (op17_code[i]) begin
        if (inst[31:15] == op17_code[i]) begin
            return op17_op[i];
        end
    end
    foreach (op7_code[i]) begin
        if (inst[31:25] == op7_code[i]) begin
            return op7_op[i];
        end
    end
    foreach (op6_code[i]) begin
        if (inst[31:26] == op6_code[i]) begin
            return op6_op[i];
        end
    end
    return ALU_NOP;
endfunction

function automatic dispatch_pkt_t expect_decode(input word_t pc, input word_t inst);
    dispatch_pkt_t p;
    aluop_e        op;
    word_t         si12;
    word_t         si20;
    op         = classify(inst);
    si12       = $signed(inst[21:10]);
    si20       = {inst[24:5], 12'h000};
    p.pc         = pc;
    p.aluop      = op;
    p.alusel     = SEL_NOP;
    p.read_en    = 2'b00;
    p.read_addr0 = inst[9:5];
    p.read_addr1 = inst[14:10];
    p.write_en   = 1'b0;
    p.write_addr = inst[4:0];
    p.imm        = '0;
    p.exc        = 1'b0;
    p.exc_cause  = INE;
    case (op)
        ALU_NOP: begin
            p.exc = 1'b1;
        end
        ALU_BREAK, ALU_SYSCALL: begin
            p.exc       = 1'b1;
            p.exc_cause = (op == ALU_BREAK) ? BRK : SYS;
        end
        ALU_SLTI, ALU_SLTUI, ALU_ADDIW, ALU_ANDI, ALU_ORI, ALU_XORI,
        ALU_SLLIW, ALU_SRLIW, ALU_SRAIW, ALU_LU12I, ALU_PCADDU12I: begin
            p.alusel   = SEL_ARITH;
            p.read_en  = 2'b01;
            p.write_en = 1'b1;
            if (op inside {ALU_SLTI, ALU_SLTUI, ALU_ADDIW}) begin
                p.imm = si12;
            end else if (op inside {ALU_ANDI, ALU_ORI, ALU_XORI}) begin
                p.imm = {20'h0, inst[21:10]};
            end else if (op inside {ALU_SLLIW, ALU_SRLIW, ALU_SRAIW}) begin
                p.imm = {27'h0, inst[14:10]};
            end else begin
                p.imm = si20;
            end
            // lu12i.w adds to r0
            if (op == ALU_LU12I) begin
                p.read_addr0 = '0;
            end
        end
        ALU_DIVW, ALU_MODW, ALU_DIVWU, ALU_MODWU: begin
            p.alusel   = SEL_DIV;
            p.read_en  = 2'b11;
            p.write_en = 1'b1;
        end
        ALU_LDB, ALU_LDH, ALU_LDW, ALU_LDBU, ALU_LDHU: begin
            p.alusel   = SEL_LOAD_STORE;
            p.read_en  = 2'b01;
            p.write_en = 1'b1;
            p.imm      = si12;
        end
        ALU_STB, ALU_STH, ALU_STW: begin
            p.alusel     = SEL_LOAD_STORE;
            p.read_en    = 2'b11;
            p.read_addr1 = inst[4:0];
        end
        ALU_BEQ, ALU_BNE, ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU: begin
            p.alusel     = SEL_JUMP_BRANCH;
            p.read_en    = 2'b11;
            p.read_addr1 = inst[4:0];
        end
        ALU_B: begin
            p.alusel = SEL_JUMP_BRANCH;
        end
        ALU_BL: begin
            p.alusel     = SEL_JUMP_BRANCH;
            p.write_en   = 1'b1;
            p.write_addr = LINK_REG;
        end
        ALU_JIRL: begin
            p.alusel   = SEL_JUMP_BRANCH;
            p.read_en  = 2'b01;
            p.write_en = 1'b1;
        end
        default: begin
            // register-register arithmetic and multiply
            p.alusel   = SEL_ARITH;
            p.read_en  = 2'b11;
            p.write_en = 1'b1;
        end
    endcase
    return p;
endfunction

// mostly kept opcodes with random fields, the rest raw random words
function automatic word_t gen_inst();
    word_t w;
    int    pick;
    w = $urandom;
    if ($urandom % 100 < 20) begin
        return w;
    end
    pick = $urandom % 48;
    if (pick < 14) begin
        w[31:22] = op10_code[pick];
    end else if (pick < 37) begin
        w[31:15] = op17_code[pick - 14];
    end else if (pick < 39) begin
        w[31:25] = op7_code[pick - 37];
    end else begin
        w[31:26] = op6_code[pick - 39];
    end
    return w;
endfunction

`endif

// ==== verif/decode_stage_tb.sv ====
`timescale 1ns/100ps

module decode_stage_tb;

    import decode_pkg::*;

    localparam int    N_INSTS     = 2000;
    localparam int    BURST_LEN   = 64;
    // about four cycles per packet under random stalls is ample
    localparam int    CYCLE_LIMIT = 4 * N_INSTS + 200;
    localparam word_t PC_BASE     = 32'h1c00_0000;

    logic       clk_i;
    logic       arst_n_i;
    logic       in_valid_i;
    word_t      pc_i;
    word_t      inst_i;
    logic       in_ready_o;
    logic       out_valid_o;
    logic       out_ready_i;
    word_t      pc_o;
    aluop_e     aluop_o;
    alusel_e    alusel_o;
    logic [1:0] read_en_o;
    reg_addr_t  read_addr0_o;
    reg_addr_t  read_addr1_o;
    logic       write_en_o;
    reg_addr_t  write_addr_o;
    word_t      imm_o;
    logic       exc_o;
    exc_cause_e exc_cause_o;

    `include "decode_model.svh"

    dispatch_pkt_t exp_q[$];
    int            accept_q[$];
    int            accepted;
    int            delivered;
    int            cycle;
    int            stall_left;
    bit            holding;

    decode_stage dut_i (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .in_valid_i   (in_valid_i),
        .pc_i         (pc_i),
        .inst_i       (inst_i),
        .in_ready_o   (in_ready_o),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .pc_o         (pc_o),
        .aluop_o      (aluop_o),
        .alusel_o     (alusel_o),
        .read_en_o    (read_en_o),
        .read_addr0_o (read_addr0_o),
        .read_addr1_o (read_addr1_o),
        .write_en_o   (write_en_o),
        .write_addr_o (write_addr_o),
        .imm_o        (imm_o),
        .exc_o        (exc_o),
        .exc_cause_o  (exc_cause_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #50 clk_i = ~clk_i;
    end

    task automatic stop_run();
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_ctrl(input aluop_e got_op, input aluop_e exp_op,
                              input alusel_e got_sel, input alusel_e exp_sel);
        if (got_op !== exp_op) begin
            $display("Error at %0t: aluop_o got %0d (%s) expected %0d (%s)",
                     $time, got_op, got_op.name(), exp_op, exp_op.name());
            stop_run();
        end
        if (got_sel !== exp_sel) begin
            $display("Error at %0t: alusel_o got %0d (%s) expected %0d (%s)",
                     $time, got_sel, got_sel.name(), exp_sel, exp_sel.name());
            stop_run();
        end
    endtask

    task automatic check_regs(input string en_name, input logic got_en, input logic exp_en,
                              input string addr_name, input reg_addr_t got_addr,
                              input reg_addr_t exp_addr);
        if (got_en !== exp_en) begin
            $display("Error at %0t: %s got %b expected %b", $time, en_name, got_en, exp_en);
            stop_run();
        end
        if (got_addr !== exp_addr) begin
            $display("Error at %0t: %s got %0d expected %0d",
                     $time, addr_name, got_addr, exp_addr);
            stop_run();
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp_val);
        if (got !== exp_val) begin
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp_val);
            stop_run();
        end
    endtask

    task automatic check_exc(input logic got_exc, input logic exp_exc,
                             input exc_cause_e got_cause, input exc_cause_e exp_cause);
        if (got_exc !== exp_exc) begin
            $display("Error at %0t: exc_o got %b expected %b", $time, got_exc, exp_exc);
            stop_run();
        end
        if (exp_exc && got_cause !== exp_cause) begin
            $display("Error at %0t: exc_cause_o got %h expected %h",
                     $time, got_cause, exp_cause);
            stop_run();
        end
    endtask

    task automatic drive_inputs();
        bit burst;
        // first packets run with both sides always ready
        burst = (delivered < BURST_LEN);
        if (!holding) begin
            if (accepted < N_INSTS && (burst || $urandom % 100 < 80)) begin
                in_valid_i = 1'b1;
                pc_i       = PC_BASE + 4 * accepted;
                inst_i     = gen_inst();
                holding    = 1'b1;
            end else begin
                in_valid_i = 1'b0;
                pc_i       = $urandom;
                inst_i     = $urandom;
            end
        end
        if (burst) begin
            out_ready_i = 1'b1;
        end else if (stall_left > 0) begin
            out_ready_i = 1'b0;
            stall_left--;
        end else if ($urandom % 16 == 0) begin
            out_ready_i = 1'b0;
            stall_left  = $urandom % 8;
        end else begin
            out_ready_i = ($urandom % 100 < 85);
        end
    endtask

    task automatic observe();
        dispatch_pkt_t e;
        int            acc;
        logic          exp_ready;
        // both slots full and the consumer stalled
        exp_ready = !((accepted - delivered == 2) && !out_ready_i);
        if (in_ready_o !== exp_ready) begin
            $display("Error at %0t: in_ready_o got %b expected %b",
                     $time, in_ready_o, exp_ready);
            stop_run();
        end
        if (out_valid_o === 1'b1 && out_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("a packet came out with none in flight at %0t", $time);
                stop_run();
            end
            e   = exp_q.pop_front();
            acc = accept_q.pop_front();
            check_word("pc_o", pc_o, e.pc);
            check_ctrl(aluop_o, e.aluop, alusel_o, e.alusel);
            check_regs("read_en_o[0]", read_en_o[0], e.read_en[0],
                       "read_addr0_o", read_addr0_o, e.read_addr0);
            check_regs("read_en_o[1]", read_en_o[1], e.read_en[1],
                       "read_addr1_o", read_addr1_o, e.read_addr1);
            check_regs("write_en_o", write_en_o, e.write_en,
                       "write_addr_o", write_addr_o, e.write_addr);
            check_word("imm_o", imm_o, e.imm);
            check_exc(exc_o, e.exc, exc_cause_o, e.exc_cause);
            if (delivered < BURST_LEN && cycle != acc + 2) begin
                $display("Error at %0t: output latency got %0d expected 2 cycles",
                         $time, cycle - acc);
                stop_run();
            end
            delivered++;
        end
        if (in_valid_i && in_ready_o === 1'b1) begin
            exp_q.push_back(expect_decode(pc_i, inst_i));
            accept_q.push_back(cycle);
            accepted++;
            holding = 1'b0;
        end
    endtask

    initial begin
        void'($urandom(9106));
        arst_n_i    = 1'b0;
        in_valid_i  = 1'b0;
        pc_i        = '0;
        inst_i      = '0;
        out_ready_i = 1'b0;
        accepted    = 0;
        delivered   = 0;
        cycle       = 0;
        stall_left  = 0;
        holding     = 1'b0;
        repeat (16) @(posedge clk_i);
        @(negedge clk_i);
        arst_n_i = 1'b1;
        #10;
        if (out_valid_o !== 1'b0 || in_ready_o !== 1'b1) begin
            $display("after reset the stage is not empty and ready");
            stop_run();
        end
        while (delivered < N_INSTS) begin
            @(negedge clk_i);
            drive_inputs();
            #10;
            observe();
            cycle++;
            if (cycle >= CYCLE_LIMIT) begin
                $display("timeout with %0d of %0d packets out after %0d cycles",
                         delivered, N_INSTS, cycle);
                stop_run();
            end
        end
        // nothing may follow the last packet
        repeat (4) begin
            @(negedge clk_i);
            in_valid_i  = 1'b0;
            out_ready_i = 1'b1;
            #10;
            if (out_valid_o !== 1'b0) begin
                $display("an extra packet came out after the last one");
                stop_run();
            end
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== src.f ====
+incdir+verif
common/decode_pkg.sv
hw/pipe_slot.sv
decode/alu_decoder.sv
decode/mem_branch_decoder.sv
decode/inst_decoder.sv
hw/decode_stage.sv
verif/decode_stage_tb.sv
